// File: redmule_ctrl_pkg.sv
// Shared definitions of the matrix-multiply control unit
// Register map, redundancy codes, array size and the bus and scheduler structs
`default_nettype none

package redmule_ctrl_pkg;

  // Rows in the processing array
  localparam int unsigned ARRAY_HEIGHT = 4;
  localparam int unsigned ROW_CNT_W    = 16;
  localparam int unsigned WCOMP_W      = $clog2(ARRAY_HEIGHT) + 1;
  localparam int unsigned REG_ADDR_W   = 8;
  localparam int unsigned ID_W         = 8;
  localparam int unsigned RED_W        = 16;

  localparam logic [REG_ADDR_W-1:0] REG_TRIGGER     = 8'h00;
  localparam logic [REG_ADDR_W-1:0] REG_STATUS      = 8'h04;
  localparam logic [REG_ADDR_W-1:0] REG_SOFT_CLEAR  = 8'h08;
  localparam logic [REG_ADDR_W-1:0] REG_W_ITERS     = 8'h0C;
  localparam logic [REG_ADDR_W-1:0] REG_LEFT_PARAMS = 8'h10;
  localparam logic [REG_ADDR_W-1:0] REG_REDUNDANCY  = 8'h14;

  // Any other selection word is treated as a corrupted register
  localparam logic [RED_W-1:0] RED_ENABLED  = 16'h00FF;
  localparam logic [RED_W-1:0] RED_DISABLED = 16'hFF00;

  // Compare points of the weight-computed and row counters
  localparam logic [WCOMP_W-1:0]   W_ACC_CNT  = WCOMP_W'(ARRAY_HEIGHT - 1);
  localparam logic [WCOMP_W-1:0]   W_LAST_CNT = WCOMP_W'(ARRAY_HEIGHT - 2);
  localparam logic [ROW_CNT_W-1:0] ROW_HEIGHT = ROW_CNT_W'(ARRAY_HEIGHT);

  // The wen bit is high for a read
  typedef struct packed {
    logic            req;
    logic [31:0]     add;
    logic            wen;
    logic [3:0]      be;
    logic [31:0]     data;
    logic [ID_W-1:0] id;
  } periph_req_t;

  typedef struct packed {
    logic            gnt;
    logic [31:0]     r_data;
    logic            r_valid;
    logic [ID_W-1:0] r_id;
  } periph_rsp_t;

  typedef struct packed {
    logic first_load;
    logic storing;
    logic finished;
    logic rst;
  } sched_ctrl_t;

  typedef struct packed {
    logic full;
    logic empty;
  } zbuf_flags_t;

endpackage

`default_nettype wire

// File: redmule_ctrl_regs.sv
// Peripheral register slave of the control unit
// Holds the job configuration and turns trigger and clear writes into pulses
`default_nettype none

module redmule_ctrl_regs (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  redmule_ctrl_pkg::periph_req_t          periph_req_i,
  output redmule_ctrl_pkg::periph_rsp_t          periph_rsp_o,
  input  logic                                   busy_i,
  input  logic                                   done_i,
  output logic                                   start_o,
  output logic                                   clear_o,
  output logic                                   evt_o,
  output logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] w_rows_iter_o,
  output logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] tot_stores_o,
  output logic [redmule_ctrl_pkg::RED_W-1:0]     redundancy_sel_o
);

  logic [redmule_ctrl_pkg::REG_ADDR_W-1:0] addr;
  logic                                    wr_en;
  logic                                    rd_en;
  logic [31:0]                             w_iters_q;
  logic [31:0]                             left_params_q;
  logic [31:0]                             redundancy_q;
  logic [31:0]                             rdata;
  logic                                    start_q;
  logic                                    clear_q;
  logic                                    r_valid_q;
  logic [31:0]                             r_data_q;
  logic [redmule_ctrl_pkg::ID_W-1:0]       r_id_q;

  // Merge the write data into a register byte by byte
  function automatic logic [31:0] be_merge(input logic [31:0] old_w,
                                           input logic [31:0] new_w,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign addr  = periph_req_i.add[redmule_ctrl_pkg::REG_ADDR_W-1:0];
  assign wr_en = periph_req_i.req & ~periph_req_i.wen;
  assign rd_en = periph_req_i.req & periph_req_i.wen;

  // A soft clear wipes the job configuration as well
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      w_iters_q     <= '0;
      left_params_q <= '0;
      redundancy_q  <= '0;
    end else if (wr_en) begin
      case (addr)
        redmule_ctrl_pkg::REG_W_ITERS:
          w_iters_q <= be_merge(w_iters_q, periph_req_i.data, periph_req_i.be);
        redmule_ctrl_pkg::REG_LEFT_PARAMS:
          left_params_q <= be_merge(left_params_q, periph_req_i.data, periph_req_i.be);
        redmule_ctrl_pkg::REG_REDUNDANCY:
          redundancy_q <= be_merge(redundancy_q, periph_req_i.data, periph_req_i.be);
        redmule_ctrl_pkg::REG_SOFT_CLEAR: begin
          w_iters_q     <= '0;
          left_params_q <= '0;
          redundancy_q  <= '0;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q   <= 1'b0;
      clear_q   <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      start_q   <= wr_en && (addr == redmule_ctrl_pkg::REG_TRIGGER);
      clear_q   <= wr_en && (addr == redmule_ctrl_pkg::REG_SOFT_CLEAR);
      r_valid_q <= periph_req_i.req;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (periph_req_i.req) begin
      r_id_q   <= periph_req_i.id;
      r_data_q <= rd_en ? rdata : '0;
    end
  end

  always_comb begin
    rdata = '0;
    case (addr)
      redmule_ctrl_pkg::REG_STATUS:      rdata[0] = busy_i;
      redmule_ctrl_pkg::REG_W_ITERS:     rdata = w_iters_q;
      redmule_ctrl_pkg::REG_LEFT_PARAMS: rdata = left_params_q;
      redmule_ctrl_pkg::REG_REDUNDANCY:  rdata = redundancy_q;
      default:                           rdata = '0;
    endcase
  end

  // The slave never stalls, so the grant follows the request
  always_comb begin
    periph_rsp_o.gnt     = periph_req_i.req;
    periph_rsp_o.r_data  = r_data_q;
    periph_rsp_o.r_valid = r_valid_q;
    periph_rsp_o.r_id    = r_id_q;
  end

  assign start_o          = start_q;
  assign clear_o          = clear_q;
  assign evt_o            = done_i;
  assign w_rows_iter_o    = w_iters_q[31:16];
  assign tot_stores_o     = left_params_q[31:16];
  assign redundancy_sel_o = redundancy_q[15:0];

endmodule

`default_nettype wire

// File: redmule_ctrl_fault.sv
// Fault combiner of the control unit
// Decides when a running job has to be aborted
`default_nettype none

module redmule_ctrl_fault (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               running_i,
  input  logic                               serial_fault_i,
  input  logic                               parallel_fault_i,
  input  logic [redmule_ctrl_pkg::RED_W-1:0] redundancy_sel_i,
  output logic                               abort_o
);

  logic parallel_fault_q;
  logic serial_abort;
  logic sel_corrupt;

  // The parallel fault comes back from the output voters, so it is
  // registered once to keep the path to the outputs free of loops
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parallel_fault_q <= 1'b0;
    end else begin
      parallel_fault_q <= parallel_fault_i;
    end
  end

  // Serial faults only count while software redundancy is not switched off
  assign serial_abort = serial_fault_i &&
                        (redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED);

  // A selection word that is neither code means the register got corrupted.
  // Outside a job software may be rewriting it, so it is not checked then
  assign sel_corrupt = running_i &&
                       (redundancy_sel_i != redmule_ctrl_pkg::RED_ENABLED) &&
                       (redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED);

  assign abort_o = parallel_fault_q | serial_abort | sel_corrupt;

endmodule

`default_nettype wire

// File: redmule_ctrl_fsm.sv
// Job sequencing FSM of the control unit
// Tracks loaded rows, computed weights, accumulation and output stores
`default_nettype none

module redmule_ctrl_fsm (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  logic                                   start_i,
  input  logic                                   clear_i,
  input  logic                                   abort_i,
  input  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] w_rows_iter_i,
  input  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] tot_stores_i,
  input  logic                                   w_loaded_i,
  input  logic                                   reg_enable_i,
  input  redmule_ctrl_pkg::zbuf_flags_t          zbuf_flags_i,
  output logic                                   running_o,
  output logic                                   busy_o,
  output logic                                   done_o,
  output logic                                   flush_o,
  output logic                                   accumulate_o,
  output logic                                   z_fill_o,
  output logic                                   w_shift_o,
  output logic                                   z_buffer_clk_en_o,
  output redmule_ctrl_pkg::sched_ctrl_t          sched_ctrl_o
);

  typedef enum logic [2:0] {
    IDLE, STARTING, COMPUTING, BUFFERING, STORING, FINISHED
  } state_e;

  state_e                                 state_q, state_d;
  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] w_row_cnt_q, w_row_cnt_d;
  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] store_cnt_q, store_cnt_d;
  logic [redmule_ctrl_pkg::WCOMP_W-1:0]   w_comp_q;
  logic                                   count_w_q, w_comp_en, w_comp_rst;
  logic                                   last_row_q, last_row_en, last_row_rst;
  logic                                   acc_q, acc_en, acc_rst;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      w_row_cnt_q <= '0;
      store_cnt_q <= '0;
    end else if (clear_i) begin
      state_q     <= IDLE;
      w_row_cnt_q <= '0;
      store_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      w_row_cnt_q <= w_row_cnt_d;
      store_cnt_q <= store_cnt_d;
    end
  end

  // Weights leaving the last PE are only counted once enough rows are in
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_w_q  <= 1'b0;
      w_comp_q   <= '0;
      last_row_q <= 1'b0;
      acc_q      <= 1'b0;
    end else if (clear_i) begin
      count_w_q  <= 1'b0;
      w_comp_q   <= '0;
      last_row_q <= 1'b0;
      acc_q      <= 1'b0;
    end else begin
      if (w_comp_rst) begin
        count_w_q <= 1'b0;
        w_comp_q  <= '0;
      end else begin
        if (w_comp_en) count_w_q <= 1'b1;
        if (count_w_q && reg_enable_i) w_comp_q <= w_comp_q + 1'b1;
      end
      if (last_row_rst) last_row_q <= 1'b0;
      else if (last_row_en) last_row_q <= 1'b1;
      if (acc_rst) acc_q <= 1'b0;
      else if (acc_en) acc_q <= 1'b1;
    end
  end

  always_comb begin
    state_d           = state_q;
    w_row_cnt_d       = w_row_cnt_q;
    store_cnt_d       = store_cnt_q;
    sched_ctrl_o      = '0;
    busy_o            = 1'b1;
    done_o            = 1'b0;
    flush_o           = 1'b0;
    z_fill_o          = 1'b0;
    w_shift_o         = 1'b1;
    z_buffer_clk_en_o = 1'b0;
    w_comp_en         = 1'b0;
    w_comp_rst        = 1'b0;
    last_row_en       = 1'b0;
    last_row_rst      = 1'b0;
    acc_en            = 1'b0;
    acc_rst           = 1'b0;

    case (state_q)
      IDLE: begin
        busy_o      = 1'b0;
        w_shift_o   = 1'b0;
        w_row_cnt_d = '0;
        store_cnt_d = '0;
        // Let the output buffer see the soft clear
        if (clear_i) z_buffer_clk_en_o = 1'b1;
        if (start_i) state_d = STARTING;
      end
      STARTING: begin
        w_shift_o               = 1'b0;
        sched_ctrl_o.first_load = 1'b1;
        if (w_loaded_i) begin
          w_row_cnt_d = w_row_cnt_q + 1'b1;
          state_d     = COMPUTING;
        end
      end
      COMPUTING: begin
        if (w_loaded_i) w_row_cnt_d = w_row_cnt_q + 1'b1;
        if (w_row_cnt_d == redmule_ctrl_pkg::ROW_HEIGHT && !count_w_q) begin
          w_comp_en = 1'b1;
        end else if (w_row_cnt_q == w_rows_iter_i) begin
          w_comp_en   = !count_w_q;
          last_row_en = !last_row_q;
        end
        if (!last_row_q) begin
          if (w_comp_q == redmule_ctrl_pkg::W_ACC_CNT) begin
            acc_en     = !acc_q;
            w_comp_rst = count_w_q;
          end
        end else if (w_comp_q == redmule_ctrl_pkg::W_LAST_CNT && reg_enable_i) begin
          // The next tile already has its first row in flight
          w_row_cnt_d    = '0;
          w_row_cnt_d[0] = 1'b1;
          acc_rst        = acc_q;
          w_comp_rst     = count_w_q;
          state_d        = BUFFERING;
        end
      end
      BUFFERING: begin
        z_buffer_clk_en_o = 1'b1;
        z_fill_o          = reg_enable_i;
        last_row_rst      = last_row_q;
        if (w_loaded_i) w_row_cnt_d = w_row_cnt_q + 1'b1;
        if (zbuf_flags_i.full) begin
          acc_en  = 1'b1;
          state_d = STORING;
        end
      end
      STORING: begin
        sched_ctrl_o.storing = 1'b1;
        if (w_loaded_i) w_row_cnt_d = w_row_cnt_q + 1'b1;
        if (zbuf_flags_i.empty) begin
          store_cnt_d = store_cnt_q + 1'b1;
          if (store_cnt_q == tot_stores_i - 1'b1) begin
            store_cnt_d           = '0;
            sched_ctrl_o.finished = 1'b1;
            state_d               = FINISHED;
          end else begin
            state_d = COMPUTING;
          end
        end
      end
      FINISHED: begin
        busy_o                = 1'b0;
        done_o                = 1'b1;
        flush_o               = 1'b1;
        sched_ctrl_o.rst      = 1'b1;
        sched_ctrl_o.finished = 1'b1;
        w_row_cnt_d           = '0;
        store_cnt_d           = '0;
        w_comp_rst            = 1'b1;
        acc_rst               = 1'b1;
        last_row_rst          = 1'b1;
        state_d               = IDLE;
      end
      default: state_d = IDLE;
    endcase

    // A fault ends the job through the normal finish path
    if (abort_i && state_q != FINISHED) state_d = FINISHED;
  end

  assign running_o    = (state_q != IDLE) && (state_q != FINISHED);
  assign accumulate_o = acc_q & reg_enable_i;

endmodule

`default_nettype wire

// File: redmule_ctrl.sv
// Control unit of the matrix-multiply accelerator
// Joins the register slave, the fault combiner and the job FSM
`default_nettype none

module redmule_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  redmule_ctrl_pkg::periph_req_t periph_req_i,
  output redmule_ctrl_pkg::periph_rsp_t periph_rsp_o,
  input  logic                          w_loaded_i,
  input  logic                          reg_enable_i,
  input  redmule_ctrl_pkg::zbuf_flags_t zbuf_flags_i,
  input  logic                          serial_fault_i,
  input  logic                          parallel_fault_i,
  output logic                          busy_o,
  output logic                          clear_o,
  output logic                          evt_o,
  output logic                          flush_o,
  output logic                          accumulate_o,
  output logic                          z_fill_o,
  output logic                          w_shift_o,
  output logic                          z_buffer_clk_en_o,
  output redmule_ctrl_pkg::sched_ctrl_t sched_ctrl_o
);

  logic                                   start;
  logic                                   clear;
  logic                                   done;
  logic                                   running;
  logic                                   abort;
  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] w_rows_iter;
  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] tot_stores;
  logic [redmule_ctrl_pkg::RED_W-1:0]     redundancy_sel;

  redmule_ctrl_regs i_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .periph_req_i     (periph_req_i),
    .periph_rsp_o     (periph_rsp_o),
    .busy_i           (busy_o),
    .done_i           (done),
    .start_o          (start),
    .clear_o          (clear),
    .evt_o            (evt_o),
    .w_rows_iter_o    (w_rows_iter),
    .tot_stores_o     (tot_stores),
    .redundancy_sel_o (redundancy_sel)
  );

  redmule_ctrl_fault i_fault (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .running_i        (running),
    .serial_fault_i   (serial_fault_i),
    .parallel_fault_i (parallel_fault_i),
    .redundancy_sel_i (redundancy_sel),
    .abort_o          (abort)
  );

  redmule_ctrl_fsm i_fsm (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .start_i           (start),
    .clear_i           (clear),
    .abort_i           (abort),
    .w_rows_iter_i     (w_rows_iter),
    .tot_stores_i      (tot_stores),
    .w_loaded_i        (w_loaded_i),
    .reg_enable_i      (reg_enable_i),
    .zbuf_flags_i      (zbuf_flags_i),
    .running_o         (running),
    .busy_o            (busy_o),
    .done_o            (done),
    .flush_o           (flush_o),
    .accumulate_o      (accumulate_o),
    .z_fill_o          (z_fill_o),
    .w_shift_o         (w_shift_o),
    .z_buffer_clk_en_o (z_buffer_clk_en_o),
    .sched_ctrl_o      (sched_ctrl_o)
  );

  assign clear_o = clear;

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
// Testbench clock and reset source
// 10 ns clock, reset held low for the first 10 cycles
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o  = 1'b0;
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

  always #5 clk_o = ~clk_o;

endmodule

`default_nettype wire

// File: redmule_ctrl_properties.sv
// Timing rules of the matrix-multiply control unit
// Bound into the top level; every violation raises an assertion error
`default_nettype none

module redmule_ctrl_properties (
  input logic                                   clk_i,
  input logic                                   rst_ni,
  input redmule_ctrl_pkg::periph_req_t          periph_req_i,
  input redmule_ctrl_pkg::periph_rsp_t          periph_rsp_o,
  input redmule_ctrl_pkg::zbuf_flags_t          zbuf_flags_i,
  input logic                                   parallel_fault_i,
  input logic                                   serial_fault_i,
  input logic                                   start_i,
  input logic                                   clear_i,
  input logic                                   running_i,
  input logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] tot_stores_i,
  input logic [redmule_ctrl_pkg::RED_W-1:0]     redundancy_sel_i,
  input logic                                   busy_o,
  input logic                                   clear_o,
  input logic                                   evt_o,
  input logic                                   flush_o,
  input logic                                   accumulate_o,
  input logic                                   z_fill_o,
  input logic                                   w_shift_o,
  input logic                                   z_buffer_clk_en_o,
  input redmule_ctrl_pkg::sched_ctrl_t          sched_ctrl_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int                                   fails = 0;
  logic                                 seen_start_q;
  logic                                 aborted_q;
  logic [redmule_ctrl_pkg::ROW_CNT_W-1:0] stores_q;
  logic                                 wr_req;
  logic [redmule_ctrl_pkg::REG_ADDR_W-1:0] wr_addr;
  logic                                 fault_hit;

  assign wr_req  = periph_req_i.req && !periph_req_i.wen;
  assign wr_addr = periph_req_i.add[redmule_ctrl_pkg::REG_ADDR_W-1:0];

  // Fault inputs that must end a running job, so that a serial fault with
  // redundancy switched off still has to run the job to its last store
  assign fault_hit = parallel_fault_i ||
                     (serial_fault_i &&
                      redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED) ||
                     (redundancy_sel_i != redmule_ctrl_pkg::RED_ENABLED &&
                      redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED);

  // Count the stores of a job and note whether a fault should end it early
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seen_start_q <= 1'b0;
      aborted_q    <= 1'b0;
      stores_q     <= '0;
    end else if (start_i) begin
      seen_start_q <= 1'b1;
      aborted_q    <= 1'b0;
      stores_q     <= '0;
    end else begin
      if (running_i && fault_hit) aborted_q <= 1'b1;
      if (sched_ctrl_o.storing && zbuf_flags_i.empty) stores_q <= stores_q + 1'b1;
    end
  end

  a_quiet_until_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_start_q |-> !(busy_o || evt_o || flush_o || accumulate_o || z_fill_o ||
                        w_shift_o || z_buffer_clk_en_o || clear_o || (|sched_ctrl_o)))
    else begin $error("control output active before the first trigger"); fails++; end

  a_grant: assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_rsp_o.gnt == periph_req_i.req)
    else begin $error("grant does not follow the request"); fails++; end

  a_response: assert property (@(posedge clk_i) disable iff (!rst_ni)
    periph_req_i.req |=> periph_rsp_o.r_valid &&
                         periph_rsp_o.r_id == $past(periph_req_i.id))
    else begin $error("missing or mismatched bus response"); fails++; end

  a_start_delay: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req && wr_addr == redmule_ctrl_pkg::REG_TRIGGER && !busy_o && !evt_o
      |=> !busy_o ##1 busy_o)
    else begin $error("busy does not rise two cycles after the trigger"); fails++; end

  a_starting: assert property (@(posedge clk_i) disable iff (!rst_ni)
    sched_ctrl_o.first_load |-> busy_o && !w_shift_o)
    else begin $error("weights shift during the first load"); fails++; end

  a_finish: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o |-> flush_o && sched_ctrl_o.finished && sched_ctrl_o.rst && !busy_o)
    else begin $error("done event without the finish outputs"); fails++; end

  a_single_evt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o |=> !evt_o)
    else begin $error("done event longer than one cycle"); fails++; end

  a_store_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_o && !aborted_q |-> stores_q == tot_stores_i)
    else begin $error("job ended after the wrong number of stores"); fails++; end

  a_parallel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    running_i && parallel_fault_i && !clear_i |-> ##2 flush_o)
    else begin $error("parallel fault did not flush after two cycles"); fails++; end

  a_serial: assert property (@(posedge clk_i) disable iff (!rst_ni)
    running_i && serial_fault_i && !clear_i &&
    redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED |=> flush_o)
    else begin $error("serial fault did not flush after one cycle"); fails++; end

  a_corrupt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    running_i && !clear_i && redundancy_sel_i != redmule_ctrl_pkg::RED_ENABLED &&
    redundancy_sel_i != redmule_ctrl_pkg::RED_DISABLED |=> flush_o)
    else begin $error("corrupted redundancy word did not flush"); fails++; end

  a_soft_clear: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_req && wr_addr == redmule_ctrl_pkg::REG_SOFT_CLEAR |=> clear_o ##1 !busy_o)
    else begin $error("soft clear did not stop the job"); fails++; end

endmodule

`default_nettype wire

// File: tb_redmule_ctrl.sv
// Testbench of the matrix-multiply control unit
// Runs jobs, fault aborts and a soft clear against the bound assertions
`default_nettype none

module tb_redmule_ctrl;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 2000;

  logic                          clk;
  logic                          rst_n;
  redmule_ctrl_pkg::periph_req_t periph_req;
  redmule_ctrl_pkg::periph_rsp_t periph_rsp;
  redmule_ctrl_pkg::zbuf_flags_t zbuf_flags;
  redmule_ctrl_pkg::sched_ctrl_t sched_ctrl;
  logic w_loaded, reg_enable, serial_fault, parallel_fault;
  logic busy, clear, evt, flush, accumulate, z_fill, w_shift, z_buf_en;
  logic [31:0] lfsr_q = 32'h7201;
  logic [7:0]  next_id = 8'h00;
  logic [7:0]  fill_cnt;
  logic [7:0]  store_wait;
  logic [31:0] rd_data;
  logic        timed_out = 1'b0;
  int          errors = 0;
  int          evt_cnt = 0;
  int          jobs_done = 0;

  tb_clk_gen i_clk_gen (.clk_o(clk), .rst_no(rst_n));

  redmule_ctrl i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .periph_req_i (periph_req), .periph_rsp_o (periph_rsp),
    .w_loaded_i (w_loaded), .reg_enable_i (reg_enable), .zbuf_flags_i (zbuf_flags),
    .serial_fault_i (serial_fault), .parallel_fault_i (parallel_fault),
    .busy_o (busy), .clear_o (clear), .evt_o (evt), .flush_o (flush),
    .accumulate_o (accumulate), .z_fill_o (z_fill), .w_shift_o (w_shift),
    .z_buffer_clk_en_o (z_buf_en), .sched_ctrl_o (sched_ctrl)
  );

  bind redmule_ctrl redmule_ctrl_properties i_props (
    .clk_i (clk_i), .rst_ni (rst_ni), .periph_req_i (periph_req_i),
    .periph_rsp_o (periph_rsp_o), .zbuf_flags_i (zbuf_flags_i),
    .parallel_fault_i (parallel_fault_i), .serial_fault_i (serial_fault_i),
    .start_i (start), .clear_i (clear), .running_i (running),
    .tot_stores_i (tot_stores), .redundancy_sel_i (redundancy_sel),
    .busy_o (busy_o), .clear_o (clear_o), .evt_o (evt_o), .flush_o (flush_o),
    .accumulate_o (accumulate_o), .z_fill_o (z_fill_o), .w_shift_o (w_shift_o),
    .z_buffer_clk_en_o (z_buffer_clk_en_o), .sched_ctrl_o (sched_ctrl_o)
  );

  // Galois LFSR stepped once per bit taken
  function automatic logic [7:0] lfsr_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[6:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // The engine model loads rows while computing, fills the buffer and then empties it
  always @(posedge clk) begin
    w_loaded   <= (sched_ctrl.first_load || (busy && !z_buf_en && !sched_ctrl.storing)) &&
                  !w_loaded;
    fill_cnt   <= z_buf_en ? fill_cnt + {7'd0, z_fill} : 8'd0;
    zbuf_flags.full  <= z_buf_en && (fill_cnt >= 8'd3);
    store_wait <= sched_ctrl.storing ? store_wait + 8'd1 : 8'd0;
    zbuf_flags.empty <= sched_ctrl.storing && (store_wait >= 8'd2);
    reg_enable <= |lfsr_bits(2);
  end

  always @(negedge clk) begin
    if (evt) evt_cnt++;
  end

  // Later waits return at once after a timeout so the run still reaches its end
  task automatic report_timeout(input string what);
    $display("Timeout while waiting for %s", what);
    timed_out = 1'b1;
    errors++;
  endtask

  // One bus transfer that returns the response data
  task automatic bus_access(input logic [7:0] addr, input logic rd,
                            input logic [31:0] data, output logic [31:0] rdata);
    int t;
    @(posedge clk);
    periph_req <= '{req: 1'b1, add: {24'h0, addr}, wen: rd, be: 4'hF, data: data, id: next_id};
    next_id = next_id + 8'd1;
    @(posedge clk);
    periph_req.req <= 1'b0;
    for (t = 0; t < 10 && !timed_out; t++) begin
      @(negedge clk);
      if (periph_rsp.r_valid) break;
    end
    if (t == 10) report_timeout("a bus response");
    rdata = periph_rsp.r_data;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic wait_busy(input logic level);
    int t;
    for (t = 0; t < TIMEOUT && !timed_out; t++) begin
      @(negedge clk);
      if (busy == level) break;
    end
    if (t == TIMEOUT) report_timeout("the busy flag");
  endtask

  task automatic wait_evt(input int target);
    int t;
    for (t = 0; t < TIMEOUT && !timed_out; t++) begin
      @(negedge clk);
      if (evt_cnt >= target) break;
    end
    if (t == TIMEOUT) report_timeout("the done event");
  endtask

  // Fault kind 0 runs a clean job, 1 a parallel, 2 a serial fault and 3 a bad redundancy word
  task automatic run_job(input logic [15:0] red, input int fault);
    int          iter;
    int          tot;
    logic [31:0] dummy;
    iter = (int'(lfsr_bits(3)) % 6) + 1;
    tot  = (int'(lfsr_bits(2)) % 3) + 1;
    bus_access(redmule_ctrl_pkg::REG_W_ITERS, 1'b0, {16'(iter), 16'h0}, dummy);
    bus_access(redmule_ctrl_pkg::REG_LEFT_PARAMS, 1'b0, {16'(tot), 16'h0}, dummy);
    bus_access(redmule_ctrl_pkg::REG_REDUNDANCY, 1'b0, {16'h0, red}, dummy);
    bus_access(redmule_ctrl_pkg::REG_W_ITERS, 1'b1, '0, rd_data);
    check_word("w_iters", rd_data, {16'(iter), 16'h0});
    bus_access(redmule_ctrl_pkg::REG_LEFT_PARAMS, 1'b1, '0, rd_data);
    check_word("left_params", rd_data, {16'(tot), 16'h0});
    bus_access(redmule_ctrl_pkg::REG_REDUNDANCY, 1'b1, '0, rd_data);
    check_word("redundancy", rd_data, {16'h0, red});
    bus_access(redmule_ctrl_pkg::REG_TRIGGER, 1'b0, '0, dummy);
    wait_busy(1'b1);
    repeat (3) @(posedge clk);
    if (fault == 1) parallel_fault <= 1'b1;
    if (fault == 2) serial_fault <= 1'b1;
    @(posedge clk);
    parallel_fault <= 1'b0;
    serial_fault   <= 1'b0;
    if (fault == 3) bus_access(redmule_ctrl_pkg::REG_REDUNDANCY, 1'b0, 32'h1234, dummy);
    jobs_done++;
    wait_evt(jobs_done);
  endtask

  initial begin
    int          t;
    logic [31:0] dummy;
    periph_req     = '0;
    zbuf_flags     = '0;
    w_loaded       = 1'b0;
    reg_enable     = 1'b0;
    serial_fault   = 1'b0;
    parallel_fault = 1'b0;
    fill_cnt       = '0;
    store_wait     = '0;
    for (t = 0; t < 100; t++) begin
      @(negedge clk);
      if (rst_n) break;
    end
    if (t == 100) report_timeout("the end of reset");
    repeat (5) @(posedge clk);
    bus_access(redmule_ctrl_pkg::REG_STATUS, 1'b1, '0, rd_data);
    check_word("status", rd_data, 32'h0);
    for (int j = 0; j < 4; j++) run_job(redmule_ctrl_pkg::RED_ENABLED, 0);
    run_job(redmule_ctrl_pkg::RED_ENABLED, 1);
    run_job(redmule_ctrl_pkg::RED_ENABLED, 2);
    run_job(redmule_ctrl_pkg::RED_DISABLED, 2);
    run_job(redmule_ctrl_pkg::RED_ENABLED, 3);
    // Soft clear in the middle of a job
    bus_access(redmule_ctrl_pkg::REG_REDUNDANCY, 1'b0, 32'h00FF, dummy);
    bus_access(redmule_ctrl_pkg::REG_LEFT_PARAMS, 1'b0, 32'h0003_0000, dummy);
    bus_access(redmule_ctrl_pkg::REG_W_ITERS, 1'b0, 32'h0004_0000, dummy);
    bus_access(redmule_ctrl_pkg::REG_TRIGGER, 1'b0, '0, dummy);
    wait_busy(1'b1);
    repeat (4) @(posedge clk);
    bus_access(redmule_ctrl_pkg::REG_SOFT_CLEAR, 1'b0, '0, dummy);
    wait_busy(1'b0);
    bus_access(redmule_ctrl_pkg::REG_W_ITERS, 1'b1, '0, rd_data);
    check_word("w_iters", rd_data, 32'h0);
    repeat (5) @(posedge clk);
    if (evt_cnt != jobs_done) begin
      $display("Saw %0d done events for %0d jobs", evt_cnt, jobs_done);
      errors++;
    end
    $display("Checks done: %0d check errors, %0d assertion failures",
             errors, i_dut.i_props.fails);
    if (errors == 0 && i_dut.i_props.fails == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
redmule_ctrl_pkg.sv
redmule_ctrl_regs.sv
redmule_ctrl_fault.sv
redmule_ctrl_fsm.sv
redmule_ctrl.sv
tb_clk_gen.sv
redmule_ctrl_properties.sv
tb_redmule_ctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module tb_redmule_ctrl -o sim_tb \
  && ./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
test -s sim.log && ! grep -q "SIMULATION FAILED" sim.log \
  && grep -q "SIMULATION PASSED" sim.log && echo "run passed" \
  || { echo "run failed"; exit 1; }
